//--- project.f
adc_pkg.sv
conv_sequencer.sv
lane_deserializer.sv
sample_conditioner.sv
sample_fifo.sv
adc_capture_top.sv
adc_lane_model.sv
tb_checker.sv
tb_adc_capture.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f project.f --top-module tb_adc_capture -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
echo "Simulation finished without failure"

//--- tb_adc_capture.sv
`timescale 1ns/1ps

module tb_adc_capture
  import adc_pkg::*;
();

  localparam int         n_rows         = 24;
  localparam int         dco_delay      = 2;
  localparam int         timeout_cycles = n_rows * conv_period * 3 + 200;
  localparam logic [1:0] mode_high      = 2'd0;
  localparam logic [1:0] mode_rand      = 2'd1;
  localparam logic [1:0] mode_low       = 2'd2;

  typedef struct packed {
    logic [95:0] name;
    sample_t     ch0_raw;
    sample_t     ch1_raw;
    sample_t     ch0_off;
    sample_t     ch1_off;
    logic [1:0]  mode;
  } row_t;

  logic         clk;
  logic         rst_n;
  logic         run;
  logic         out_ready;
  sample_t      ch0_offset;
  sample_t      ch1_offset;
  sample_t      ch0_word;
  sample_t      ch1_word;
  logic         din0_a;
  logic         din0_b;
  logic         din1_a;
  logic         din1_b;
  logic         dco;
  logic         cnv;
  logic         clkout;
  sample_pair_t out_pair;
  logic         out_valid;
  logic         overflow;
  logic         exp_valid;
  sample_pair_t exp_pair;
  logic [95:0]  exp_name;
  logic         idle_check;
  logic         ovf_check;
  logic         ovf_expect;
  logic         stop_watch;
  int           pending;
  int           mismatches;
  int           failures;
  logic [1:0]   ready_mode;
  integer       seed;
  int           cycle_count;
  int           held;
  row_t         rows [n_rows];

  adc_capture_top adc_capture_top_inst (
    .clk(clk), .rst_n(rst_n), .run(run),
    .ch0_offset(ch0_offset), .ch1_offset(ch1_offset),
    .din0_a(din0_a), .din0_b(din0_b), .din1_a(din1_a), .din1_b(din1_b), .dco(dco),
    .cnv(cnv), .clkout(clkout),
    .out_pair(out_pair), .out_valid(out_valid), .out_ready(out_ready), .overflow(overflow)
  );

  adc_lane_model #(.dco_delay(dco_delay)) adc_lane_model_inst (
    .clk(clk), .rst_n(rst_n), .cnv(cnv), .clkout(clkout),
    .ch0_word(ch0_word), .ch1_word(ch1_word), .dco(dco),
    .din0_a(din0_a), .din0_b(din0_b), .din1_a(din1_a), .din1_b(din1_b)
  );

  tb_checker tb_checker_inst (
    .clk(clk), .rst_n(rst_n), .cnv(cnv), .clkout(clkout),
    .out_pair(out_pair), .out_valid(out_valid), .out_ready(out_ready), .overflow(overflow),
    .exp_valid(exp_valid), .exp_pair(exp_pair), .exp_name(exp_name),
    .idle_check(idle_check), .ovf_check(ovf_check), .ovf_expect(ovf_expect),
    .stop_watch(stop_watch), .pending(pending), .mismatches(mismatches), .failures(failures)
  );

  always #20 clk = ~clk;

  // Raw minus offset clamped to the 18-bit signed range
  function automatic sample_t expected_sample(int raw, int offset);
    int diff;
    diff = raw - offset;
    if (diff > 131071) begin
      diff = 131071;
    end else if (diff < -131072) begin
      diff = -131072;
    end
    return sample_t'(diff);
  endfunction

  task automatic set_row(int idx, logic [95:0] name, int c0, int c1, int o0, int o1,
                         logic [1:0] mode);
    rows[idx].name    = name;
    rows[idx].ch0_raw = sample_t'(c0);
    rows[idx].ch1_raw = sample_t'(c1);
    rows[idx].ch0_off = sample_t'(o0);
    rows[idx].ch1_off = sample_t'(o1);
    rows[idx].mode    = mode;
  endtask

  task automatic build_table();
    set_row(0, "zero_ones", 'h3FFFF, 'h20000, 0, 0, mode_high);
    set_row(1, "zero_alt", 'h15555, 'h0AAAA, 0, 0, mode_high);
    set_row(2, "off_plain", 1000, -2000, 300, -500, mode_high);
    set_row(3, "sat_high", 131000, -7, -500, 0, mode_high);
    set_row(4, "sat_low", -131000, 131071, 500, 131071, mode_high);
    for (int i = 5; i < 9; i++) begin
      set_row(i, "rand_ready", $random(seed), $random(seed), 77, -33, mode_rand);
    end
    set_row(9, "drain", 4242, -4242, 0, 0, mode_high);
    for (int i = 10; i < 22; i++) begin
      set_row(i, "hold_low", i * 4099, -i * 2731, 0, 0, mode_low);
    end
    set_row(22, "resume", 12345, -54321, 0, 0, mode_high);
    set_row(23, "last", -1, 1, 1, -1, mode_high);
  endtask

  // Returns on the edge where the model samples the new conversion
  task automatic wait_conv_start();
    @(posedge clk);
    while (cnv) @(posedge clk);
    while (!cnv) @(posedge clk);
  endtask

  task automatic apply_row(int idx);
    logic is_low;
    is_low = (rows[idx].mode == mode_low);
    ch0_offset <= rows[idx].ch0_off;
    ch1_offset <= rows[idx].ch1_off;
    ready_mode <= rows[idx].mode;
    if (idx + 1 < n_rows) begin
      ch0_word <= rows[idx+1].ch0_raw;   // Next conversion's sample
      ch1_word <= rows[idx+1].ch1_raw;
    end else begin
      run <= 1'b0;
    end
    if (is_low && held == 0) begin
      ovf_check  <= 1'b1;
      ovf_expect <= 1'b0;
    end else if (!is_low && held > 0) begin
      ovf_check  <= 1'b1;
      ovf_expect <= 1'b1;
    end
    held = is_low ? held + 1 : 0;
    exp_name  <= rows[idx].name;
    exp_pair  <= {expected_sample(rows[idx].ch0_raw, rows[idx].ch0_off),
                  expected_sample(rows[idx].ch1_raw, rows[idx].ch1_off)};
    exp_valid <= (held <= fifo_depth);  // Pairs past a full FIFO are lost
    @(posedge clk);
    exp_valid <= 1'b0;
    ovf_check <= 1'b0;
  endtask

  always @(posedge clk) begin
    case (ready_mode)
      mode_high: out_ready <= 1'b1;
      mode_rand: out_ready <= (($random(seed) & 1) == 1);
      default:   out_ready <= 1'b0;
    endcase
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout: run did not complete within %0d cycles", timeout_cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    run         = 1'b0;
    out_ready   = 1'b0;
    ch0_offset  = '0;
    ch1_offset  = '0;
    ch0_word    = '0;
    ch1_word    = '0;
    exp_valid   = 1'b0;
    exp_pair    = '0;
    exp_name    = '0;
    idle_check  = 1'b0;
    ovf_check   = 1'b0;
    ovf_expect  = 1'b0;
    stop_watch  = 1'b0;
    ready_mode  = mode_high;
    seed        = 21981;
    cycle_count = 0;
    held        = 0;
    build_table();
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);
    idle_check <= 1'b1;
    @(posedge clk);
    idle_check <= 1'b0;
    ch0_word   <= rows[0].ch0_raw;
    ch1_word   <= rows[0].ch1_raw;
    run        <= 1'b1;
    for (int i = 0; i < n_rows; i++) begin
      wait_conv_start();
      apply_row(i);
    end
    @(posedge clk);
    while (pending != 0) @(posedge clk);
    stop_watch <= 1'b1;
    repeat (2 * conv_period) @(posedge clk);
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- tb_checker.sv
`timescale 1ns/1ps

module tb_checker
  import adc_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         cnv,
  input  logic         clkout,
  input  sample_pair_t out_pair,
  input  logic         out_valid,
  input  logic         out_ready,
  input  logic         overflow,
  input  logic         exp_valid,
  input  sample_pair_t exp_pair,
  input  logic [95:0]  exp_name,
  input  logic         idle_check,
  input  logic         ovf_check,
  input  logic         ovf_expect,
  input  logic         stop_watch,
  output int           pending,
  output int           mismatches,
  output int           failures
);

  sample_pair_t pair_q[$];
  logic [95:0]  name_q[$];
  sample_pair_t want;
  logic [95:0]  name;

  initial begin
    pending    = 0;
    mismatches = 0;
    failures   = 0;
  end

  always @(posedge clk) begin
    if (rst_n) begin
      if (exp_valid) begin
        pair_q.push_back(exp_pair);
        name_q.push_back(exp_name);
      end
      if (out_valid && out_ready) begin
        if (pair_q.size() == 0) begin
          failures = failures + 1;
          $display("Output pair ch0=%0d ch1=%0d arrived with no pair expected",
                   out_pair.ch0, out_pair.ch1);
        end else begin
          want = pair_q.pop_front();
          name = name_q.pop_front();
          if (out_pair !== want) begin
            mismatches = mismatches + 1;
            $display("Mismatch in %s: expected ch0=%0d ch1=%0d, actual ch0=%0d ch1=%0d",
                     name, want.ch0, want.ch1, out_pair.ch0, out_pair.ch1);
          end
        end
      end
      if (idle_check && ({cnv, clkout, out_valid, overflow} !== 4'b0000)) begin
        mismatches = mismatches + 1;
        $display("Mismatch in idle_reset: expected 0000, actual %b",
                 {cnv, clkout, out_valid, overflow});
      end
      if (ovf_check && (overflow !== ovf_expect)) begin
        mismatches = mismatches + 1;
        $display("Mismatch in overflow: expected %b, actual %b", ovf_expect, overflow);
      end
      if (stop_watch && (cnv || out_valid)) begin
        failures = failures + 1;
        $display("Converter or output still active after run stopped (cnv=%b out_valid=%b)",
                 cnv, out_valid);
      end
      pending <= pair_q.size();
    end
  end

endmodule

//--- adc_lane_model.sv
`timescale 1ns/1ps

module adc_lane_model
  import adc_pkg::*;
#(
  parameter int dco_delay = 2
) (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    cnv,
  input  logic    clkout,
  input  sample_t ch0_word,
  input  sample_t ch1_word,
  output logic    dco,
  output logic    din0_a,
  output logic    din0_b,
  output logic    din1_a,
  output logic    din1_b
);

  logic [dco_delay-1:0] echo;
  logic                 cnv_q;
  logic                 sending;
  int                   pair_idx;
  sample_pair_t         held;

  assign dco = echo[dco_delay-1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      echo     <= '0;
      cnv_q    <= 1'b0;
      sending  <= 1'b0;
      pair_idx <= 0;
      held     <= '0;
      {din0_a, din0_b, din1_a, din1_b} <= 4'b0000;
    end else begin
      echo  <= {echo[dco_delay-2:0], clkout};
      cnv_q <= cnv;
      if (cnv && !cnv_q) begin
        held <= {ch0_word, ch1_word};   // Sample taken at conversion start
      end
      if (!sending && echo[dco_delay-2] && !echo[dco_delay-1]) begin
        din0_a   <= held.ch0[sample_width-1];   // Pair 0 with the first dco high
        din0_b   <= held.ch0[sample_width-2];
        din1_a   <= held.ch1[sample_width-1];
        din1_b   <= held.ch1[sample_width-2];
        sending  <= 1'b1;
        pair_idx <= 1;
      end else if (sending && pair_idx < bits_per_lane) begin
        din0_a   <= held.ch0[sample_width-1-2*pair_idx];
        din0_b   <= held.ch0[sample_width-2-2*pair_idx];
        din1_a   <= held.ch1[sample_width-1-2*pair_idx];
        din1_b   <= held.ch1[sample_width-2-2*pair_idx];
        pair_idx <= pair_idx + 1;
      end else if (sending) begin
        sending <= 1'b0;
        {din0_a, din0_b, din1_a, din1_b} <= 4'b0000;
      end
    end
  end

endmodule

//--- adc_capture_top.sv
`timescale 1ns/1ps

module adc_capture_top
  import adc_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         run,
  input  sample_t      ch0_offset,
  input  sample_t      ch1_offset,
  input  logic         din0_a,
  input  logic         din0_b,
  input  logic         din1_a,
  input  logic         din1_b,
  input  logic         dco,
  output logic         cnv,
  output logic         clkout,
  output sample_pair_t out_pair,
  output logic         out_valid,
  input  logic         out_ready,
  output logic         overflow
);

  sample_pair_t raw_pair;
  logic         raw_valid;
  sample_pair_t cond_pair;
  logic         cond_valid;

  conv_sequencer conv_sequencer_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .run    (run),
    .cnv    (cnv),
    .clkout (clkout)
  );

  lane_deserializer lane_deserializer_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .din0_a    (din0_a),
    .din0_b    (din0_b),
    .din1_a    (din1_a),
    .din1_b    (din1_b),
    .dco       (dco),
    .raw_pair  (raw_pair),
    .raw_valid (raw_valid)
  );

  sample_conditioner sample_conditioner_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .raw_pair   (raw_pair),
    .raw_valid  (raw_valid),
    .ch0_offset (ch0_offset),
    .ch1_offset (ch1_offset),
    .cond_pair  (cond_pair),
    .cond_valid (cond_valid)
  );

  sample_fifo sample_fifo_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_pair   (cond_pair),
    .in_valid  (cond_valid),
    .out_pair  (out_pair),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .overflow  (overflow)
  );

endmodule

//--- sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo
  import adc_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  sample_pair_t in_pair,
  input  logic         in_valid,
  output sample_pair_t out_pair,
  output logic         out_valid,
  input  logic         out_ready,
  output logic         overflow
);

  sample_pair_t          mem [fifo_depth];
  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_ptr_w-1:0] rd_ptr;
  logic [fifo_cnt_w-1:0] count;
  logic                  full;
  logic                  push;
  logic                  pop;

  assign full      = (count == fifo_cnt_w'(fifo_depth));
  assign out_valid = (count != '0);
  assign push      = in_valid && !full;   // Converter cannot stall so drop
  assign pop       = out_valid && out_ready;
  assign out_pair  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_pair;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;     // Depth is a power of two
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (in_valid && full) begin
        overflow <= 1'b1;            // Sticky until reset
      end
    end
  end

  a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
    count <= fifo_cnt_w'(fifo_depth));

  a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_pair)));

endmodule

//--- sample_conditioner.sv
`timescale 1ns/1ps

module sample_conditioner
  import adc_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  sample_pair_t raw_pair,
  input  logic         raw_valid,
  input  sample_t      ch0_offset,
  input  sample_t      ch1_offset,
  output sample_pair_t cond_pair,
  output logic         cond_valid
);

  sample_pair_t next_pair;

  // One extra bit holds the full difference before the clamp
  function automatic sample_t sat_sub(input sample_t raw, input sample_t offset);
    logic signed [sample_width:0] diff;
    sample_t                      result;
    diff = raw - offset;
    if (diff > sample_max) begin
      result = sample_t'(sample_max);
    end else if (diff < sample_min) begin
      result = sample_t'(sample_min);
    end else begin
      result = sample_t'(diff);
    end
    return result;
  endfunction

  assign next_pair.ch0 = sat_sub(raw_pair.ch0, ch0_offset);
  assign next_pair.ch1 = sat_sub(raw_pair.ch1, ch1_offset);

  always_ff @(posedge clk) begin
    if (raw_valid) begin
      cond_pair <= next_pair;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cond_valid <= 1'b0;
    end else begin
      cond_valid <= raw_valid;
    end
  end

endmodule

//--- lane_deserializer.sv
`timescale 1ns/1ps

module lane_deserializer
  import adc_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         din0_a,
  input  logic         din0_b,
  input  logic         din1_a,
  input  logic         din1_b,
  input  logic         dco,
  output sample_pair_t raw_pair,
  output logic         raw_valid
);

  logic [3:0]           lanes_s1;    // {din0_a, din0_b, din1_a, din1_b}
  logic [3:0]           lanes_s2;
  logic                 dco_s1;
  logic                 dco_s2;
  logic                 dco_s3;
  logic                 dco_rise;
  logic                 busy;
  logic [bit_cnt_w-1:0] bit_cnt;
  logic                 shift_en;
  logic                 last_pair;
  logic                 pair_done;
  sample_pair_t         acc;

  // Lanes share the dco pipeline depth so they stay aligned
  always_ff @(posedge clk) begin
    lanes_s1 <= {din0_a, din0_b, din1_a, din1_b};
    lanes_s2 <= lanes_s1;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dco_s1 <= 1'b0;
      dco_s2 <= 1'b0;
      dco_s3 <= 1'b0;
    end else begin
      dco_s1 <= dco;
      dco_s2 <= dco_s1;
      dco_s3 <= dco_s2;              // Edge detect only
    end
  end

  assign dco_rise  = dco_s2 && !dco_s3;
  assign shift_en  = busy || dco_rise;   // First pair lands with the edge
  assign last_pair = busy && (bit_cnt == bit_cnt_w'(bits_per_lane - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      bit_cnt   <= '0;
      pair_done <= 1'b0;
    end else begin
      pair_done <= last_pair;
      if (!busy) begin
        if (dco_rise) begin
          busy    <= 1'b1;
          bit_cnt <= bit_cnt_w'(1);
        end
      end else if (last_pair) begin
        busy    <= 1'b0;             // Later edges of this burst ignored
        bit_cnt <= '0;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // Lane a fills odd bits, lane b even bits, MSB first
  always_ff @(posedge clk) begin
    if (shift_en) begin
      acc.ch0 <= {acc.ch0[sample_width-3:0], lanes_s2[3], lanes_s2[2]};
      acc.ch1 <= {acc.ch1[sample_width-3:0], lanes_s2[1], lanes_s2[0]};
    end
  end

  always_ff @(posedge clk) begin
    if (pair_done) begin
      raw_pair <= acc;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      raw_valid <= 1'b0;
    end else begin
      raw_valid <= pair_done;
    end
  end

  a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    raw_valid |=> !raw_valid);

endmodule

//--- conv_sequencer.sv
`timescale 1ns/1ps

module conv_sequencer
  import adc_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  output logic cnv,
  output logic clkout
);

  logic                   active;
  logic [conv_cnt_w-1:0]  period_cnt;
  logic                   period_end;
  logic                   burst_start;
  logic                   burst_on;
  logic [burst_cnt_w-1:0] burst_cnt;

  assign period_end  = active && (period_cnt == conv_cnt_w'(conv_period - 1));
  assign burst_start = active && (period_cnt == conv_cnt_w'(conv_time - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active     <= 1'b0;
      period_cnt <= '0;
    end else if (!active) begin
      active <= run;                 // Counter sits at zero while idle
    end else if (period_end) begin
      active     <= run;             // Finish period and stop if run dropped
      period_cnt <= '0;
    end else begin
      period_cnt <= period_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      burst_on  <= 1'b0;
      burst_cnt <= '0;
    end else if (burst_start) begin
      burst_on  <= 1'b1;
      burst_cnt <= '0;
    end else if (burst_on) begin
      burst_cnt <= burst_cnt + 1'b1;
      if (burst_cnt == burst_cnt_w'(burst_len - 1)) begin
        burst_on <= 1'b0;
      end
    end
  end

  assign cnv    = active && (period_cnt < conv_cnt_w'(cnv_width));
  assign clkout = burst_on && burst_cnt[0];   // High on odd counts

  // Burst must sit inside its slot of the conversion period
  a_clkout_window: assert property (@(posedge clk) disable iff (!rst_n)
    clkout |-> (active &&
                period_cnt >= conv_cnt_w'(conv_time) &&
                period_cnt <  conv_cnt_w'(conv_time + burst_len)));

endmodule

//--- adc_pkg.sv
package adc_pkg;

  // Converter word
  localparam int sample_width  = 18;
  localparam int bits_per_lane = 9;    // Bit pairs per conversion
  localparam int bit_cnt_w     = $clog2(bits_per_lane);

  localparam int sample_max = 2 ** (sample_width - 1) - 1;
  localparam int sample_min = -(2 ** (sample_width - 1));

  // Conversion timing in clk cycles
  localparam int conv_period = 40;
  localparam int conv_time   = 20;     // Start to first burst cycle
  localparam int cnv_width   = 2;
  localparam int burst_len   = 10;     // Five clkout rising edges
  localparam int conv_cnt_w  = $clog2(conv_period);
  localparam int burst_cnt_w = $clog2(burst_len);

  // Output buffer
  localparam int fifo_depth = 8;
  localparam int fifo_ptr_w = $clog2(fifo_depth);
  localparam int fifo_cnt_w = fifo_ptr_w + 1;

  typedef logic signed [sample_width-1:0] sample_t;

  typedef struct packed {
    sample_t ch0;
    sample_t ch1;
  } sample_pair_t;

endpackage
